// File: hw/board_cfg_pkg.sv
package board_cfg_pkg;

   // Power-up hold
   // Stands in for the oscillator settling time on the board
   localparam int unsigned hold_cycles = 12;                  // CLK_I cycles to core start
   localparam int unsigned hold_cnt_w  = $clog2(hold_cycles); // Width of the hold counter

   // Slave port word addresses
   // Full 32-bit compare, nothing else is mapped
   localparam logic [31:0] addr_out_port = 32'h0000_0000; // LEDs and serial transmit
   localparam logic [31:0] addr_in_port  = 32'h0000_0004; // Serial receive and status

   // Input port word layout
   localparam int unsigned in_rx_bit    = 0; // Synchronised receive level
   localparam int unsigned in_start_bit = 1; // Processor released from hold

   // Remaining input port bits read as zero
   // Unmapped addresses also read as zero

endpackage

// File: hw/wb_bus_pkg.sv
package wb_bus_pkg;

   // Wishbone classic widths
   localparam int unsigned wb_adr_w = 32;
   localparam int unsigned wb_dat_w = 32;
   localparam int unsigned wb_sel_w = wb_dat_w / 8; // One select per byte lane

   // Master to slave
   typedef struct packed {
      logic                cyc;  // Bus cycle in progress
      logic                stb;  // Strobe, held until ack seen
      logic                we;   // Write when high
      logic [wb_adr_w-1:0] adr;  // Byte address
      logic [wb_sel_w-1:0] sel;  // Byte lane selects
      logic [wb_dat_w-1:0] dat;  // Write data
   } bus_req_t;

   // Slave to master
   typedef struct packed {
      logic                ack;  // Registered acknowledge
      logic [wb_dat_w-1:0] dat;  // Read data, valid with ack
   } bus_rsp_t;

   // Output port bits, tx in bit 0 as on the board
   typedef struct packed {
      logic blue;   // Bit 3
      logic green;  // Bit 2
      logic red;    // Bit 1
      logic tx;     // Bit 0, serial transmit pin
   } port_bits_t;

   // Field view of the port data word
   typedef struct packed {
      logic [wb_dat_w-$bits(port_bits_t)-1:0] rsvd; // Ignored on write, zero on read
      port_bits_t                             bits;
   } port_fields_t;

   // One data word, raw or as port fields
   typedef union packed {
      logic [wb_dat_w-1:0] raw;
      port_fields_t        fields;
   } port_word_u;

   // Transmit line idles high, LEDs off
   localparam port_bits_t port_rst_val = '{tx: 1'b1, default: 1'b0};

endpackage

// File: hw/startup_hold.sv
`timescale 1ns/1ps

// Keeps the processor from running until the clock has settled
// Counts from reset release and then latches core_start high
module startup_hold
   import board_cfg_pkg::*;
(
   input  logic CLK_I,
   input  logic arst_n,
   output logic core_start
);

   logic [hold_cnt_w-1:0] cnt;      // Cycles since reset release
   logic                  cnt_done; // Last count reached

   // Counter stops one short of hold_cycles
   // The start flop adds the final cycle
   assign cnt_done = (cnt == hold_cnt_w'(hold_cycles - 1));

   // Saturating counter
   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         cnt <= '0;
      end else if (!cnt_done) begin
         cnt <= cnt + 1'b1; // First edge after release gives 1
      end
   end

   // Start flag, set once and held until next reset
   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         core_start <= 1'b0;
      end else if (cnt_done) begin
         core_start <= 1'b1; // Rises on edge number hold_cycles
      end
   end

   // Nothing else to clear here
   // core_start stays high through any bus traffic

endmodule

// File: hw/gpio_port.sv
`timescale 1ns/1ps

// Wishbone classic slave for the board pins
// Output port register, receive synchroniser, read mux and registered ack
module gpio_port
   import board_cfg_pkg::*;
   import wb_bus_pkg::*;
(
   input  logic       CLK_I,
   input  logic       arst_n,
   input  bus_req_t   req,
   output bus_rsp_t   rsp,
   input  logic       rx_pin,     // Asynchronous serial receive
   input  logic       core_start, // Status from the power-up hold
   output port_bits_t port        // Registered pin state
);

   logic                strobe;   // cyc and stb together
   logic                hit_out;  // Output port selected
   logic                hit_in;   // Input port selected
   logic                wr_port;  // Qualified port write
   logic                rd_cap;   // Capture read data this edge
   port_word_u          wr_word;  // Write data, decoded as fields
   port_word_u          rd_word;  // Read data before the register
   port_bits_t          port_q;
   logic                rx_meta;  // First sync stage
   logic                rx_sync;  // Second sync stage
   logic                ack_q;
   logic [wb_dat_w-1:0] rd_q;     // Read data held with ack

   // Address decode
   // Word addresses compared in full
   assign strobe  = req.cyc & req.stb;
   assign hit_out = (req.adr == addr_out_port);
   assign hit_in  = (req.adr == addr_in_port);

   // Write path
   assign wr_word.raw = req.dat;
   // Only lane 0 carries port bits
   assign wr_port = strobe & req.we & req.sel[0] & hit_out;
   assign rd_cap  = strobe & ~req.we;

   // Output port register
   // Loads on the same edge that raises ack
   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         port_q <= port_rst_val; // tx idle high, LEDs off
      end else if (wr_port) begin
         port_q <= wr_word.fields.bits;
      end
   end

   // Two-stage receive synchroniser
   // Idle level out of reset so software sees no start bit
   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= rx_pin;
         rx_sync <= rx_meta;
      end
   end

   // Read mux
   always_comb begin
      rd_word.raw = '0; // Unmapped and reserved bits read zero
      if (hit_out) begin
         rd_word.fields.bits = port_q; // Same layout as written
      end else if (hit_in) begin
         rd_word.raw[in_rx_bit]    = rx_sync;
         rd_word.raw[in_start_bit] = core_start;
      end
   end

   // Read data register
   // Sampled with the strobe, presented with ack
   // Pin to read is then at most three edges
   always_ff @(posedge CLK_I) begin
      if (rd_cap) begin
         rd_q <= rd_word.raw;
      end
   end

   // Acknowledge
   // Plain registered strobe, one cycle latency
   // Master drops stb after each ack
   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= strobe;
      end
   end

   // Outputs
   assign rsp.ack = ack_q;
   assign rsp.dat = rd_q;   // Only meaningful on read acks
   assign port    = port_q; // Pins change with ack

endmodule

// File: hw/board_io_top.sv
`timescale 1ns/1ps

// Board I/O block beside the soft processor
// Power-up hold plus the pin port on one Wishbone slave
module board_io_top
   import wb_bus_pkg::*;
(
   input  logic     CLK_I,
   input  logic     arst_n,
   input  bus_req_t req,        // From the processor bus master
   output bus_rsp_t rsp,
   input  logic     uart_rx,    // Asynchronous receive pin
   output logic     uart_tx,
   output logic     led_red,
   output logic     led_green,
   output logic     led_blue,
   output logic     core_start  // Releases the processor
);

   port_bits_t port_w;  // Registered pin state from the port block
   logic       start_w; // Hold status, also readable on the bus

   // Power-up delay
   startup_hold startup_hold_inst (
      .CLK_I      (CLK_I),
      .arst_n     (arst_n),
      .core_start (start_w)
   );

   // Bus slave and pin registers
   gpio_port gpio_port_inst (
      .CLK_I      (CLK_I),
      .arst_n     (arst_n),
      .req        (req),
      .rsp        (rsp),
      .rx_pin     (uart_rx),
      .core_start (start_w),
      .port       (port_w)
   );

   // Pins
   // Straight from flops, no logic in the path
   assign uart_tx    = port_w.tx;
   assign led_red    = port_w.red;
   assign led_green  = port_w.green;
   assign led_blue   = port_w.blue;
   assign core_start = start_w;

endmodule

// File: dv/board_io_assertions.sv
`timescale 1ns/1ps

// Bus handshake and start checks, bound onto gpio_port
module board_io_assertions
   import wb_bus_pkg::*;
(
   input logic     CLK_I,
   input logic     arst_n,
   input bus_req_t req,
   input bus_rsp_t rsp,
   input logic     core_start
);

   logic        strobe;           // cyc and stb together
   int unsigned double_ack_fails; // One counter per property
   int unsigned orphan_ack_fails;
   int unsigned start_fall_fails;
   int unsigned fail_total;       // Read by the testbench at the end

   initial begin
      double_ack_fails = 0;
      orphan_ack_fails = 0;
      start_fall_fails = 0;
   end

   assign strobe     = req.cyc & req.stb;
   assign fail_total = double_ack_fails + orphan_ack_fails + start_fall_fails;

   // Strobe still up on the ack cycle would be answered again
   double_ack_a: assert property (@(posedge CLK_I) disable iff (!arst_n)
      (rsp.ack && strobe) |=> !rsp.ack)
      else begin
         double_ack_fails = double_ack_fails + 1;
         $error("ack seen twice while the strobe stayed high");
      end

   // Registered ack, so the strobe sits one cycle earlier
   orphan_ack_a: assert property (@(posedge CLK_I) disable iff (!arst_n)
      rsp.ack |-> $past(strobe))
      else begin
         orphan_ack_fails = orphan_ack_fails + 1;
         $error("ack raised without a strobe in the cycle before");
      end

   start_hold_a: assert property (@(posedge CLK_I) disable iff (!arst_n)
      !$fell(core_start))
      else begin
         start_fall_fails = start_fall_fails + 1;
         $error("core_start fell while reset was released");
      end

endmodule

// File: dv/board_io_tb.sv
`timescale 1ns/1ps

// Testbench for the board I/O block
// Plays the Wishbone master and models the port register and input word
module board_io_tb
   import board_cfg_pkg::*;
   import wb_bus_pkg::*;
();

   localparam int          clk_half   = 20;           // 40 ns period
   localparam int          drive_dly  = 2;            // Inputs change after the edge
   localparam int          rst_cycles = 3;
   localparam logic [31:0] lfsr_seed  = 32'h63d9;
   localparam logic [31:0] lfsr_taps  = 32'h8020_0003; // Galois feedback mask

   localparam int unsigned n_writes   = 24;
   localparam int unsigned n_rx       = 16;
   localparam int unsigned n_unmapped = 4;
   // Each write is followed by a read, each unmapped access is write, read, read
   localparam int unsigned n_trans    = 2 * n_writes + n_rx + 3 * n_unmapped;
   localparam int unsigned watchdog_cycles = 200 * n_trans + hold_cycles + rst_cycles + 16;

   logic        CLK_I;
   logic        arst_n;
   bus_req_t    req;
   bus_rsp_t    rsp;
   logic        uart_rx;
   logic        uart_tx;
   logic        led_red;
   logic        led_green;
   logic        led_blue;
   logic        core_start;

   logic [31:0] lfsr_state;
   logic [3:0]  exp_port;   // Shadow of the port, tx in bit 0 and blue in bit 3
   logic        exp_rx;     // Level driven on uart_rx
   logic        exp_start;  // Start status once the hold has run
   string       test_name;

   board_io_top board_io_top_inst (
      .CLK_I      (CLK_I),
      .arst_n     (arst_n),
      .req        (req),
      .rsp        (rsp),
      .uart_rx    (uart_rx),
      .uart_tx    (uart_tx),
      .led_red    (led_red),
      .led_green  (led_green),
      .led_blue   (led_blue),
      .core_start (core_start)
   );

   // Bus and start checks sit on the slave itself
   bind gpio_port board_io_assertions board_io_assertions_inst (
      .CLK_I      (CLK_I),
      .arst_n     (arst_n),
      .req        (req),
      .rsp        (rsp),
      .core_start (core_start)
   );

   initial begin
      CLK_I = 1'b0;
      forever #clk_half CLK_I = ~CLK_I;
   end

   // Compare two words, stop at the first difference
   task automatic check_value(input string label, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("Mismatch in test %s (%s): expected 0x%08h, actual 0x%08h",
                  test_name, label, expected, actual);
         $display("Testbench failed");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ lfsr_taps;
      end
      return n;
   endfunction

   // One LFSR step per bit taken
   task automatic take_bits(input int unsigned n, output logic [31:0] val);
      val = '0;
      for (int unsigned i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         val[i] = lfsr_state[0];
      end
   endtask

   // Expected read word from the address map
   function automatic logic [31:0] expected_read(input logic [31:0] adr,
                                                 input logic [3:0] port_bits,
                                                 input logic rx_level,
                                                 input logic start_level);
      logic [31:0] word;
      word = 32'h0;                     // Unmapped and reserved bits
      if (adr == addr_out_port) begin
         word[3:0] = port_bits;         // blue green red tx
      end else if (adr == addr_in_port) begin
         word[0] = rx_level;
         word[1] = start_level;
      end
      return word;
   endfunction

   function automatic logic [31:0] unmapped_address(input int unsigned idx);
      case (idx)
         0:       return 32'h0000_0008;
         1:       return 32'h0000_0001; // Byte offset into the out port word
         2:       return 32'h0000_0100;
         default: return 32'hffff_fffc;
      endcase
   endfunction

   task automatic idle_cycles(input int unsigned n);
      repeat (n) begin
         @(posedge CLK_I);
         #drive_dly;
      end
   endtask

   // One classic cycle, entered and left 2 ns after an edge
   task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                            input logic [31:0] dat, output logic [31:0] rdat);
      int unsigned waits;
      waits   = 0;
      req.cyc = 1'b1;
      req.stb = 1'b1;
      req.we  = we;
      req.adr = adr;
      req.sel = sel;
      req.dat = dat;
      do begin
         @(posedge CLK_I);
         #drive_dly;
         waits = waits + 1;
      end while (!rsp.ack);
      check_value("ack latency", 32'd1, waits); // Registered ack, one edge after the strobe
      rdat    = rsp.dat;  // Valid while ack is high
      req.cyc = 1'b0;
      req.stb = 1'b0;
      req.we  = 1'b0;
      idle_cycles(1);     // Strobe low for a full cycle
      check_value("ack release", 32'h0, {31'h0, rsp.ack}); // Single-cycle ack pulse
   endtask

   task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
      logic [31:0] unused_rd;
      // Shadow moves first, the pins are only compared on the ack cycle
      if (adr == addr_out_port && sel[0]) begin
         exp_port = dat[3:0];
      end
      bus_cycle(1'b1, adr, sel, dat, unused_rd);
   endtask

   task automatic bus_read(input logic [31:0] adr, output logic [31:0] rdat);
      bus_cycle(1'b0, adr, 4'hf, 32'h0, rdat);
   endtask

   // Pins against the shadow on every ack
   always @(negedge CLK_I) begin
      if (arst_n && rsp.ack) begin
         check_value("pins", {28'h0, exp_port}, {28'h0, led_blue, led_green, led_red, uart_tx});
      end
   end

   initial begin
      repeat (watchdog_cycles) @(posedge CLK_I);
      $display("Timeout: the tests did not finish within %0d clock cycles", watchdog_cycles);
      $display("Testbench failed");
      $fatal(1, "Watchdog expired");
   end

   initial begin
      logic [31:0] dat;
      logic [31:0] tmp;
      logic [31:0] rdat;
      logic [31:0] adr;

      arst_n     = 1'b0;
      req        = '0;
      uart_rx    = 1'b1;  // Line idle
      lfsr_state = lfsr_seed;
      exp_port   = 4'b0001;
      exp_rx     = 1'b1;
      exp_start  = 1'b0;

      test_name = "reset";
      idle_cycles(rst_cycles);
      check_value("pins in reset", 32'h1, {28'h0, led_blue, led_green, led_red, uart_tx});
      check_value("core_start in reset", 32'h0, {31'h0, core_start});
      arst_n = 1'b1;

      // Start must rise on the hold_cycles-th edge after release and stay
      test_name = "start";
      for (int unsigned i = 1; i <= hold_cycles + 4; i++) begin
         idle_cycles(1);
         check_value("core_start", {31'h0, i >= hold_cycles}, {31'h0, core_start});
      end
      exp_start = 1'b1;

      test_name = "write and readback";
      for (int unsigned i = 0; i < n_writes; i++) begin
         take_bits(32, dat);
         take_bits(4, tmp);
         bus_write(addr_out_port, dat, tmp[3:0]);
         bus_read(addr_out_port, rdat);
         check_value("readback", expected_read(addr_out_port, exp_port, exp_rx, exp_start), rdat);
      end

      test_name = "input port";
      for (int unsigned i = 0; i < n_rx; i++) begin
         take_bits(1, tmp);
         uart_rx = tmp[0];
         exp_rx  = tmp[0];
         idle_cycles(3);     // Through both sync stages
         bus_read(addr_in_port, rdat);
         check_value("input word", expected_read(addr_in_port, exp_port, exp_rx, exp_start),
                     rdat);
      end

      test_name = "unmapped";
      for (int unsigned i = 0; i < n_unmapped; i++) begin
         adr = unmapped_address(i);
         take_bits(32, dat);
         bus_write(adr, dat, 4'hf);
         bus_read(adr, rdat);
         check_value("unmapped read", expected_read(adr, exp_port, exp_rx, exp_start), rdat);
         bus_read(addr_out_port, rdat);  // Port left alone
         check_value("port after unmapped",
                     expected_read(addr_out_port, exp_port, exp_rx, exp_start), rdat);
      end

      test_name = "end";
      idle_cycles(2);
      if (board_io_top_inst.gpio_port_inst.board_io_assertions_inst.fail_total == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: filelist.f
hw/board_cfg_pkg.sv
hw/wb_bus_pkg.sv
hw/startup_hold.sv
hw/gpio_port.sv
hw/board_io_top.sv
dv/board_io_assertions.sv
dv/board_io_tb.sv

// File: Makefile
# Verilator flow for the board I/O block

VERILATOR ?= verilator
TOP       ?= board_io_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Testbench passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the simulation prints the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
